// ==== pad_ctrl_regs.sv ====
//**************************************************************************
// Pad mux select registers on the register bus. One select per shared
// pad at address k; out of range accesses return an error.
//**************************************************************************

module pad_ctrl_regs #(
  parameter int NUM_PAD = 14
) (
  input  logic                                 clk_i,
  input  logic                                 rst_sys_i,
  input  pad_pkg::reg_req_t                    reg_req_i,
  output pad_pkg::reg_rsp_t                    reg_rsp_o,
  output pad_pkg::pad_sel_e [NUM_PAD-1:0]      pad_sel_o
);

  localparam int IDX_W = (NUM_PAD > 1) ? $clog2(NUM_PAD) : 1;

  pad_pkg::pad_sel_e [NUM_PAD-1:0] sel_q;

  logic             addr_hit;
  logic [IDX_W-1:0] idx;
  logic             wr_en;
  logic             rd_en;
  pad_pkg::pad_sel_e sel_rd;

  // Address decode against the pad count
  assign addr_hit = (32'(reg_req_i.addr) < NUM_PAD);
  assign idx      = reg_req_i.addr[IDX_W-1:0];

  assign wr_en = reg_req_i.valid && addr_hit &&
                 (reg_req_i.op == pad_pkg::REG_WRITE);
  assign rd_en = reg_req_i.valid && addr_hit &&
                 (reg_req_i.op == pad_pkg::REG_READ);

  // Select flops, all pads to the peripheral function on reset
  always_ff @(posedge clk_i) begin
    if (rst_sys_i) begin
      for (int i = 0; i < NUM_PAD; i++) begin
        sel_q[i] <= pad_pkg::PAD_SEL_PERIPH;
      end
    end else if (wr_en) begin
      sel_q[idx] <= pad_pkg::pad_sel_e'(reg_req_i.wdata[0]);
    end
  end

  // Selects read as peripheral for the whole reset window
  always_comb begin
    sel_rd = pad_pkg::PAD_SEL_PERIPH;
    if (rd_en && !rst_sys_i) begin
      sel_rd = sel_q[idx];
    end
  end

  // Single cycle response, no back-pressure
  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid && !addr_hit;
    reg_rsp_o.rdata = {{(pad_pkg::REG_DATA_W - 1){1'b0}}, sel_rd};
  end

  assign pad_sel_o = sel_q;

endmodule

// ==== pad_mux.sv ====
//**************************************************************************
// Per-pad routing between the dedicated peripheral and the GPIO. Purely
// combinational; the select comes from the pad control registers.
//**************************************************************************

module pad_mux #(
  parameter int NUM_PAD = 14
) (
  input  pad_pkg::pad_sel_e   [NUM_PAD-1:0] pad_sel_i,
  input  pad_pkg::pad_drive_t [NUM_PAD-1:0] periph_drv_i,
  input  pad_pkg::pad_drive_t [NUM_PAD-1:0] gpio_drv_i,
  input  logic                [NUM_PAD-1:0] pad_in_i,
  output pad_pkg::pad_drive_t [NUM_PAD-1:0] pad_drv_o,
  output logic                [NUM_PAD-1:0] periph_in_o,
  output logic                [NUM_PAD-1:0] gpio_in_o
);

  for (genvar i = 0; i < NUM_PAD; i++) begin : g_cell
    pad_pkg::pad_drive_t drv;
    logic                periph_in;
    logic                gpio_in;

    // Unselected function sees a constant low input
    always_comb begin
      periph_in = 1'b0;
      gpio_in   = 1'b0;
      unique case (pad_sel_i[i])
        pad_pkg::PAD_SEL_GPIO: begin
          drv     = gpio_drv_i[i];
          gpio_in = pad_in_i[i];
        end
        default: begin
          drv       = periph_drv_i[i];
          periph_in = pad_in_i[i];
        end
      endcase
    end

    assign pad_drv_o[i]   = drv;
    assign periph_in_o[i] = periph_in;
    assign gpio_in_o[i]   = gpio_in;
  end

endmodule

// ==== pad_pkg.sv ====
//**************************************************************************
// Shared types and defaults for the pad multiplexing subsystem. Referenced
// by scoped name from the register block, the pad mux and the top level.
//**************************************************************************

package pad_pkg;

  // Shared pads: 2 PDM, 3 I2S, 7 SPI2, 2 I2C
  localparam int NUM_PAD_DEFAULT = 14;

  // Internal reset stretch after the external reset drops
  localparam int RST_HOLD_DEFAULT = 4;

  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  // Register bus operation
  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  // Function owning a shared pad
  typedef enum logic {
    PAD_SEL_PERIPH = 1'b0,
    PAD_SEL_GPIO   = 1'b1
  } pad_sel_e;

  // Register bus request, sampled in the cycle valid is high
  typedef struct packed {
    logic                  valid;
    reg_op_e               op;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
  } reg_req_t;

  // Register bus response, same cycle as the request
  typedef struct packed {
    logic                  ready;
    logic                  error;
    logic [REG_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Value and enable toward one pad
  typedef struct packed {
    logic out;
    logic oe;
  } pad_drive_t;

endpackage

// ==== pad_sys_top.sv ====
//**************************************************************************
// Pad multiplexing system top. Ties the reset stretcher, the select
// registers and the pad mux together; pad count and reset hold set here.
//**************************************************************************

module pad_sys_top #(
  parameter int NUM_PAD  = pad_pkg::NUM_PAD_DEFAULT,
  parameter int RST_HOLD = pad_pkg::RST_HOLD_DEFAULT
) (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Register bus toward the select registers
  input  pad_pkg::reg_req_t                 reg_req_i,
  output pad_pkg::reg_rsp_t                 reg_rsp_o,

  // Function side of the shared pads
  input  pad_pkg::pad_drive_t [NUM_PAD-1:0] periph_drv_i,
  input  pad_pkg::pad_drive_t [NUM_PAD-1:0] gpio_drv_i,
  output logic                [NUM_PAD-1:0] periph_in_o,
  output logic                [NUM_PAD-1:0] gpio_in_o,

  // Pad side
  input  logic                [NUM_PAD-1:0] pad_in_i,
  output pad_pkg::pad_drive_t [NUM_PAD-1:0] pad_drv_o,

  output logic                              rst_sys_o
);

  pad_pkg::pad_sel_e [NUM_PAD-1:0] pad_sel;

  // Stretched reset for the control registers
  rst_gen #(
    .RST_HOLD (RST_HOLD)
  ) rst_gen_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rst_sys_o (rst_sys_o)
  );

  pad_ctrl_regs #(
    .NUM_PAD (NUM_PAD)
  ) pad_ctrl_regs_i (
    .clk_i     (clk_i),
    .rst_sys_i (rst_sys_o),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .pad_sel_o (pad_sel)
  );

  pad_mux #(
    .NUM_PAD (NUM_PAD)
  ) pad_mux_i (
    .pad_sel_i    (pad_sel),
    .periph_drv_i (periph_drv_i),
    .gpio_drv_i   (gpio_drv_i),
    .pad_in_i     (pad_in_i),
    .pad_drv_o    (pad_drv_o),
    .periph_in_o  (periph_in_o),
    .gpio_in_o    (gpio_in_o)
  );

endmodule

// ==== rst_gen.sv ====
//**************************************************************************
// Reset stretcher. Holds the system reset high for RST_HOLD cycles after
// the external reset is released.
//**************************************************************************

module rst_gen #(
  parameter int RST_HOLD = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  output logic rst_sys_o
);

  // Wide enough to hold RST_HOLD itself
  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic [CNT_W-1:0] cnt_q;

  // Reload on every external reset edge, then count down to zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= CNT_W'(RST_HOLD);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // System reset stays active until the count runs out
  assign rst_sys_o = (cnt_q != '0);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the pad mux testbench with Verilator and runs it.
# The exit status is the simulation's own status.

cd "$(dirname "$0")" || exit 1

TOP=tb_pad_sys
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
  --top-module "$TOP" \
  --Mdir "$OBJ_DIR" \
  -f vlog.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

if [ ! -x "$OBJ_DIR/V$TOP" ]; then
  echo "Simulation binary $OBJ_DIR/V$TOP was not produced"
  exit 1
fi

"./$OBJ_DIR/V$TOP"
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
  exit "$sim_status"
fi

echo "Simulation finished with status 0"
exit 0

// ==== tb_pad_sys.sv ====
//**************************************************************************
// Testbench for the pad multiplexing top. Drives the register bus and
// random pad traffic, and checks each cycle against a select model.
//**************************************************************************

module tb_pad_sys;

  localparam int NUM_PAD        = pad_pkg::NUM_PAD_DEFAULT;
  localparam int RST_HOLD       = pad_pkg::RST_HOLD_DEFAULT;
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk_i = 1'b0;
  logic rst_i;

  pad_pkg::reg_req_t                 reg_req;
  pad_pkg::reg_rsp_t                 reg_rsp;
  pad_pkg::pad_drive_t [NUM_PAD-1:0] periph_drv;
  pad_pkg::pad_drive_t [NUM_PAD-1:0] gpio_drv;
  pad_pkg::pad_drive_t [NUM_PAD-1:0] pad_drv;
  logic                [NUM_PAD-1:0] pad_in;
  logic                [NUM_PAD-1:0] periph_in;
  logic                [NUM_PAD-1:0] gpio_in;
  logic                              rst_sys;

  integer seed;
  int     cycle_cnt = 0;

  // Reference state, valid after each rising edge
  int unsigned       rst_cnt_model = RST_HOLD;
  pad_pkg::pad_sel_e sel_model [NUM_PAD];
  logic              sel_known = 1'b0;

  pad_sys_top #(
    .NUM_PAD  (NUM_PAD),
    .RST_HOLD (RST_HOLD)
  ) dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_req_i    (reg_req),
    .reg_rsp_o    (reg_rsp),
    .periph_drv_i (periph_drv),
    .gpio_drv_i   (gpio_drv),
    .periph_in_o  (periph_in),
    .gpio_in_o    (gpio_in),
    .pad_in_i     (pad_in),
    .pad_drv_o    (pad_drv),
    .rst_sys_o    (rst_sys)
  );

  initial begin
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("CHECK FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, exp_v, act_v);
    $display("TB FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
    assert (act_v === exp_v) else report_mismatch(name, exp_v, act_v);
  endtask

  // Bus response is combinational on valid
  ready_follows_valid: assert property (@(negedge clk_i) reg_rsp.ready == reg_req.valid)
    else report_mismatch("reg_rsp_o.ready", 64'(reg_req.valid), 64'(reg_rsp.ready));

  error_needs_valid: assert property (@(negedge clk_i) !reg_req.valid |-> !reg_rsp.error)
    else report_mismatch("reg_rsp_o.error", 64'(1'b0), 64'(reg_rsp.error));

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Compare outputs in the middle of the cycle, inputs are stable here
  task automatic check_cycle();
    logic                              exp_rst;
    logic                              in_range;
    logic [pad_pkg::REG_DATA_W-1:0]    exp_rdata;
    pad_pkg::pad_drive_t [NUM_PAD-1:0] exp_drv;
    logic                [NUM_PAD-1:0] exp_pin;
    logic                [NUM_PAD-1:0] exp_gin;
    int                                idx;
    exp_rst = (rst_cnt_model != 0);
    check_eq("rst_sys_o", 64'(exp_rst), 64'(rst_sys));
    if (sel_known) begin
      idx      = int'(reg_req.addr);
      in_range = (idx < NUM_PAD);
      check_eq("reg_rsp_o.error", 64'(reg_req.valid && !in_range), 64'(reg_rsp.error));
      if (reg_req.valid && (!in_range || reg_req.op == pad_pkg::REG_READ)) begin
        exp_rdata = '0;
        if (in_range && !exp_rst) begin
          exp_rdata[0] = sel_model[idx];
        end
        check_eq("reg_rsp_o.rdata", 64'(exp_rdata), 64'(reg_rsp.rdata));
      end
      for (int i = 0; i < NUM_PAD; i++) begin
        if (sel_model[i] == pad_pkg::PAD_SEL_GPIO) begin
          exp_drv[i] = gpio_drv[i];
          exp_pin[i] = 1'b0;
          exp_gin[i] = pad_in[i];
        end else begin
          exp_drv[i] = periph_drv[i];
          exp_pin[i] = pad_in[i];
          exp_gin[i] = 1'b0;
        end
      end
      check_eq("pad_drv_o", 64'(exp_drv), 64'(pad_drv));
      check_eq("periph_in_o", 64'(exp_pin), 64'(periph_in));
      check_eq("gpio_in_o", 64'(exp_gin), 64'(gpio_in));
    end
  endtask

  // Apply what the next rising edge does to the selects and the counter
  task automatic advance_model();
    int idx;
    idx = int'(reg_req.addr);
    if (rst_cnt_model != 0) begin
      for (int i = 0; i < NUM_PAD; i++) begin
        sel_model[i] = pad_pkg::PAD_SEL_PERIPH;
      end
      sel_known = 1'b1;
    end else if (reg_req.valid && reg_req.op == pad_pkg::REG_WRITE && idx < NUM_PAD) begin
      sel_model[idx] = pad_pkg::pad_sel_e'(reg_req.wdata[0]);
    end
    if (rst_i) begin
      rst_cnt_model = RST_HOLD;
    end else if (rst_cnt_model != 0) begin
      rst_cnt_model = rst_cnt_model - 1;
    end
  endtask

  always @(negedge clk_i) begin
    check_cycle();
    advance_model();
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // One bus request plus fresh random pad traffic
  task automatic drive_cycle(input logic valid, input pad_pkg::reg_op_e op,
                             input int addr, input logic [pad_pkg::REG_DATA_W-1:0] wdata);
    pad_pkg::reg_req_t req;
    req.valid = valid;
    req.op    = op;
    req.addr  = pad_pkg::REG_ADDR_W'(addr);
    req.wdata = wdata;
    @(posedge clk_i);
    reg_req    <= req;
    periph_drv <= (2*NUM_PAD)'($random(seed));
    gpio_drv   <= (2*NUM_PAD)'($random(seed));
    pad_in     <= NUM_PAD'($random(seed));
  endtask

  task automatic read_all();
    for (int a = 0; a < NUM_PAD; a++) begin
      drive_cycle(1'b1, pad_pkg::REG_READ, a, 32'h0);
    end
  endtask

  // Alternates GPIO writes and reads through the reset window, then times the release
  task automatic apply_reset(input int cycles);
    int n;
    n = 0;
    repeat (cycles - 1) begin
      drive_cycle(1'b1, (n % 2 == 1) ? pad_pkg::REG_READ : pad_pkg::REG_WRITE,
                  rand_below(NUM_PAD), 32'h1);
      rst_i <= 1'b1;
      n++;
    end
    drive_cycle(1'b1, pad_pkg::REG_WRITE, rand_below(NUM_PAD), 32'h1);
    rst_i <= 1'b0;
    n = 0;
    do begin
      drive_cycle(n + 1 < RST_HOLD, pad_pkg::REG_WRITE, rand_below(NUM_PAD), 32'h1);
      n++;
      @(negedge clk_i);
    end while (rst_sys && n < 4 * RST_HOLD);
    check_eq("rst_sys_o release edges", 64'(RST_HOLD), 64'(n));
  endtask

  initial begin
    int a;
    seed       = 14041;
    rst_i      = 1'b1;
    reg_req    = '0;
    periph_drv = '0;
    gpio_drv   = '0;
    pad_in     = '0;

    apply_reset(5);
    read_all();

    // Peripheral routing on every pad
    repeat (40) begin
      drive_cycle(1'b0, pad_pkg::REG_READ, 0, 32'h0);
    end

    // Random selects with readback
    repeat (60) begin
      a = rand_below(NUM_PAD);
      drive_cycle(1'b1, pad_pkg::REG_WRITE, a, $random(seed));
      drive_cycle(1'b1, pad_pkg::REG_READ, a, 32'h0);
    end

    for (int addr = NUM_PAD; addr < 256; addr++) begin
      drive_cycle(1'b1, (rand_below(2) == 1) ? pad_pkg::REG_WRITE : pad_pkg::REG_READ,
                  addr, $random(seed));
    end
    read_all();

    // Every pad on GPIO before the mid-run reset
    for (int p = 0; p < NUM_PAD; p++) begin
      drive_cycle(1'b1, pad_pkg::REG_WRITE, p, 32'h1);
    end

    // Mid-run reset drops every GPIO select
    apply_reset(6);
    read_all();
    drive_cycle(1'b0, pad_pkg::REG_READ, 0, 32'h0);
    @(posedge clk_i);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
pad_pkg.sv
rst_gen.sv
pad_ctrl_regs.sv
pad_mux.sv
pad_sys_top.sv
tb_pad_sys.sv
